// File: verilog/addrParams.svh
`ifndef ADDR_PARAMS_SVH
`define ADDR_PARAMS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

// Data bus, index registers, adder and address halves
`define ADDR_DATA_W 8

// Full address bus, high and low byte
`define ADDR_ADDR_W 16

//////////////////////////////////////////////////
// Sequencing
//////////////////////////////////////////////////

// Longest operand step sequence, the indirect modes
`define ADDR_STEP_MAX 4

`endif

// File: verilog/addrPkg.sv
package addrPkg;

    // Opcodes the unit knows by name
    typedef enum logic [7:0] {
        LDA_INDX = 8'hA1,
        LDA_ZPG  = 8'hA5,
        LDA_IMM  = 8'hA9,
        LDA_ABS  = 8'hAD,
        LDA_INDY = 8'hB1,
        LDA_ZPGX = 8'hB5,
        LDX_ZPGY = 8'hB6,
        LDA_ABSY = 8'hB9,
        LDA_ABSX = 8'hBD,
        NOP      = 8'hEA
    } opCode_t;

    typedef enum logic [3:0] {
        MODE_IMP, MODE_IMM, MODE_ZPG, MODE_ZPGX, MODE_ZPGY,
        MODE_ABS, MODE_ABSX, MODE_ABSY, MODE_INDX, MODE_INDY
    } addrMode_t;

    // A0..A3 encode as operand step index plus one
    typedef enum logic [2:0] {
        STEP_IDLE = 3'd0,
        STEP_A0   = 3'd1,
        STEP_A1   = 3'd2,
        STEP_A2   = 3'd3,
        STEP_A3   = 3'd4,
        STEP_DONE = 3'd5
    } addrStep_t;

    typedef enum logic [1:0] {ADL_PCL, ADL_DATA, ADL_ALU} adlSrc_t;
    typedef enum logic [1:0] {ADH_PCH, ADH_DATA, ADH_ZERO, ADH_ALU} adhSrc_t;
    typedef enum logic [1:0] {SB_X, SB_Y, SB_ALU, SB_NONE} sbSrc_t;
    typedef enum logic {ALUA_SB, ALUA_ZERO} aluASrc_t;
    typedef enum logic [1:0] {CIN_ZERO, CIN_ONE, CIN_LATCH} aluCSrc_t;

    // Control word for one step
    typedef struct packed {
        logic     pcInc;
        logic     loadAbl;
        adlSrc_t  adlSel;
        logic     loadAbh;
        adhSrc_t  adhSel;
        sbSrc_t   sbSel;
        logic     dbFromSb;
        aluASrc_t aluASel;
        aluCSrc_t aluCSel;
        logic     loadAlu;
        logic     latchCarry;
    } ctrlFlags_t;

endpackage

// File: verilog/addrModeDecode.sv
module addrModeDecode import addrPkg::*; (
    input  logic [7:0] opCode,
    output addrMode_t  mode,
    output logic [2:0] stepCount
);

    //////////////////////////////////////////////////
    // Opcode to addressing mode
    //////////////////////////////////////////////////

    always_comb begin
        case (opCode)
            LDA_IMM:  mode = MODE_IMM;
            LDA_ZPG:  mode = MODE_ZPG;
            LDA_ZPGX: mode = MODE_ZPGX;
            LDX_ZPGY: mode = MODE_ZPGY;
            LDA_ABS:  mode = MODE_ABS;
            LDA_ABSX: mode = MODE_ABSX;
            LDA_ABSY: mode = MODE_ABSY;
            LDA_INDX: mode = MODE_INDX;
            LDA_INDY: mode = MODE_INDY;
            NOP:      mode = MODE_IMP;
            // Anything unknown runs as implied
            default:  mode = MODE_IMP;
        endcase
    end

    //////////////////////////////////////////////////
    // Fixed operand step count per mode
    //////////////////////////////////////////////////

    always_comb begin
        case (mode)
            MODE_IMM, MODE_ZPG:             stepCount = 3'd1;
            MODE_ZPGX, MODE_ZPGY, MODE_ABS: stepCount = 3'd2;
            // Extra step for the carry into the high byte
            MODE_ABSX, MODE_ABSY:           stepCount = 3'd3;
            MODE_INDX, MODE_INDY:           stepCount = 3'd4;
            default:                        stepCount = 3'd0;
        endcase
    end

endmodule

// File: verilog/addrStepCtrl.sv
`include "addrParams.svh"

module addrStepCtrl import addrPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       start,
    input  addrMode_t  mode,
    input  logic [2:0] stepCount,
    input  logic       aluCarry,
    input  logic       latchCarry,
    output addrStep_t  step,
    output addrMode_t  curMode,
    output logic       carryHold,
    output logic       accept,
    output logic       busy,
    output logic       done
);

    logic [2:0] stepCnt;
    addrStep_t  stepNext;

    assign busy   = (step != STEP_IDLE);
    assign done   = (step == STEP_DONE);
    // Start is dropped while an instruction is in flight
    assign accept = start && !busy;

    always_comb begin
        stepNext = step;
        case (step)
            STEP_IDLE: begin
                if (accept) begin
                    stepNext = (stepCount == 3'd0) ? STEP_DONE : STEP_A0;
                end
            end
            STEP_DONE: begin
                stepNext = STEP_IDLE;
            end
            default: begin
                // Last operand step once index matches the count
                if (3'(step) == stepCnt) begin
                    stepNext = STEP_DONE;
                end else begin
                    stepNext = addrStep_t'(3'(step) + 3'd1);
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            step      <= STEP_IDLE;
            curMode   <= MODE_IMP;
            stepCnt   <= 3'd0;
            carryHold <= 1'b0;
        end else begin
            step <= stepNext;
            if (accept) begin
                curMode <= mode;
                stepCnt <= stepCount;
            end
            // Low-byte index carry, used by the high-byte step
            if (latchCarry) begin
                carryHold <= aluCarry;
            end
        end
    end

    stepInRange: assert property (@(posedge clk) disable iff (!arstN)
        (step inside {STEP_A0, STEP_A1, STEP_A2, STEP_A3}) |->
            (3'(step) <= stepCnt) && (stepCnt <= `ADDR_STEP_MAX));

endmodule

// File: verilog/addrFlagGen.sv
module addrFlagGen import addrPkg::*; (
    input  addrStep_t  step,
    input  addrMode_t  curMode,
    input  logic       carryHold,
    output ctrlFlags_t flags
);

    // Nothing loads, no bus driven
    localparam ctrlFlags_t FLAGS_IDLE = '{
        pcInc:      1'b0,
        loadAbl:    1'b0,
        adlSel:     ADL_PCL,
        loadAbh:    1'b0,
        adhSel:     ADH_PCH,
        sbSel:      SB_NONE,
        dbFromSb:   1'b0,
        aluASel:    ALUA_ZERO,
        aluCSel:    CIN_ZERO,
        loadAlu:    1'b0,
        latchCarry: 1'b0
    };

    sbSrc_t idxSel;

    // Y-indexed modes put Y on SB, the others X
    assign idxSel = (curMode inside {MODE_ZPGY, MODE_ABSY, MODE_INDY}) ? SB_Y : SB_X;

    always_comb begin
        flags = FLAGS_IDLE;
        case (curMode)
            MODE_IMM: begin
                // Operand address already on the bus
                if (step == STEP_A0) begin
                    flags.pcInc = 1'b1;
                end
            end
            MODE_ZPG: begin
                if (step == STEP_A0) begin
                    flags.pcInc   = 1'b1;
                    flags.loadAbl = 1'b1;
                    flags.adlSel  = ADL_DATA;
                    flags.loadAbh = 1'b1;
                    flags.adhSel  = ADH_ZERO;
                end
            end
            MODE_ZPGX, MODE_ZPGY: begin
                if (step == STEP_A0) begin
                    flags.pcInc   = 1'b1;
                    flags.sbSel   = idxSel;
                    flags.aluASel = ALUA_SB;
                    flags.loadAlu = 1'b1;
                end else if (step == STEP_A1) begin
                    // 8-bit sum wraps inside page zero
                    flags.loadAbl = 1'b1;
                    flags.adlSel  = ADL_ALU;
                    flags.loadAbh = 1'b1;
                    flags.adhSel  = ADH_ZERO;
                end
            end
            MODE_ABS, MODE_ABSX, MODE_ABSY: begin
                case (step)
                    STEP_A0: begin
                        // Point at high byte, low byte into ALU
                        flags.pcInc   = 1'b1;
                        flags.loadAbl = 1'b1;
                        flags.adlSel  = ADL_PCL;
                        flags.loadAbh = 1'b1;
                        flags.adhSel  = ADH_PCH;
                        flags.loadAlu = 1'b1;
                        if (curMode != MODE_ABS) begin
                            flags.sbSel      = idxSel;
                            flags.aluASel    = ALUA_SB;
                            flags.latchCarry = 1'b1;
                        end
                    end
                    STEP_A1: begin
                        flags.pcInc   = 1'b1;
                        flags.loadAbl = 1'b1;
                        flags.adlSel  = ADL_ALU;
                        if (curMode == MODE_ABS) begin
                            flags.loadAbh = 1'b1;
                            flags.adhSel  = ADH_DATA;
                        end else begin
                            // High byte plus page carry
                            flags.aluCSel = CIN_LATCH;
                            flags.loadAlu = 1'b1;
                        end
                    end
                    STEP_A2: begin
                        flags.loadAbh = 1'b1;
                        flags.adhSel  = ADH_ALU;
                    end
                    default: begin
                    end
                endcase
            end
            MODE_INDX: begin
                case (step)
                    STEP_A0: begin
                        flags.pcInc   = 1'b1;
                        flags.sbSel   = SB_X;
                        flags.aluASel = ALUA_SB;
                        flags.loadAlu = 1'b1;
                    end
                    STEP_A1: begin
                        flags.loadAbl  = 1'b1;
                        flags.adlSel   = ADL_ALU;
                        flags.loadAbh  = 1'b1;
                        flags.adhSel   = ADH_ZERO;
                        // Pointer plus one, fed back over SB
                        flags.sbSel    = SB_ALU;
                        flags.dbFromSb = 1'b1;
                        flags.aluCSel  = CIN_ONE;
                        flags.loadAlu  = 1'b1;
                    end
                    STEP_A2: begin
                        flags.loadAbl = 1'b1;
                        flags.adlSel  = ADL_ALU;
                        flags.loadAbh = 1'b1;
                        flags.adhSel  = ADH_ZERO;
                        flags.loadAlu = 1'b1;
                    end
                    STEP_A3: begin
                        flags.loadAbl = 1'b1;
                        flags.adlSel  = ADL_ALU;
                        flags.loadAbh = 1'b1;
                        flags.adhSel  = ADH_DATA;
                    end
                    default: begin
                    end
                endcase
            end
            MODE_INDY: begin
                case (step)
                    STEP_A0: begin
                        flags.pcInc   = 1'b1;
                        flags.loadAbl = 1'b1;
                        flags.adlSel  = ADL_DATA;
                        flags.loadAbh = 1'b1;
                        flags.adhSel  = ADH_ZERO;
                        flags.aluCSel = CIN_ONE;
                        flags.loadAlu = 1'b1;
                    end
                    STEP_A1: begin
                        flags.loadAbl    = 1'b1;
                        flags.adlSel     = ADL_ALU;
                        flags.loadAbh    = 1'b1;
                        flags.adhSel     = ADH_ZERO;
                        flags.sbSel      = SB_Y;
                        flags.aluASel    = ALUA_SB;
                        flags.loadAlu    = 1'b1;
                        flags.latchCarry = 1'b1;
                    end
                    STEP_A2: begin
                        flags.aluCSel = CIN_LATCH;
                        flags.loadAlu = 1'b1;
                    end
                    STEP_A3: begin
                        flags.loadAbl = 1'b1;
                        flags.adlSel  = ADL_ALU;
                        flags.loadAbh = 1'b1;
                        flags.adhSel  = ADH_ALU;
                    end
                    default: begin
                    end
                endcase
            end
            default: begin
            end
        endcase

        // Held carry resolves to a plain carry in
        if (flags.aluCSel == CIN_LATCH) begin
            flags.aluCSel = carryHold ? CIN_ONE : CIN_ZERO;
        end
    end

endmodule

// File: verilog/addrDatapath.sv
`include "addrParams.svh"

module addrDatapath import addrPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  ctrlFlags_t              flags,
    input  logic                    accept,
    input  logic                    pcLoad,
    input  logic [`ADDR_ADDR_W-1:0] pcIn,
    input  logic [`ADDR_DATA_W-1:0] xReg,
    input  logic [`ADDR_DATA_W-1:0] yReg,
    input  logic [`ADDR_DATA_W-1:0] dataIn,
    output logic [`ADDR_ADDR_W-1:0] addrBus,
    output logic [`ADDR_ADDR_W-1:0] pc,
    output logic                    aluCarry
);

    localparam logic [`ADDR_ADDR_W-1:0] PC_STEP = 1;

    logic [`ADDR_DATA_W-1:0] abl;
    logic [`ADDR_DATA_W-1:0] abh;
    logic [`ADDR_DATA_W-1:0] aluReg;
    logic [`ADDR_DATA_W-1:0] lowHold;
    logic [`ADDR_DATA_W-1:0] sbBus;
    logic [`ADDR_DATA_W-1:0] dbBus;
    logic [`ADDR_DATA_W-1:0] adlBus;
    logic [`ADDR_DATA_W-1:0] adhBus;
    logic [`ADDR_DATA_W-1:0] aluA;
    logic [`ADDR_DATA_W-1:0] aluSum;
    logic                    aluCin;

    //////////////////////////////////////////////////
    // Internal buses
    //////////////////////////////////////////////////

    always_comb begin
        case (flags.sbSel)
            SB_X:    sbBus = xReg;
            SB_Y:    sbBus = yReg;
            SB_ALU:  sbBus = aluReg;
            default: sbBus = '0;
        endcase
    end

    assign dbBus  = flags.dbFromSb ? sbBus : dataIn;
    assign aluA   = (flags.aluASel == ALUA_SB) ? sbBus : '0;
    assign aluCin = (flags.aluCSel == CIN_ONE);

    // 8-bit adder, carry out goes to the sequencer
    assign {aluCarry, aluSum} = {1'b0, aluA} + {1'b0, dbBus} + {{`ADDR_DATA_W{1'b0}}, aluCin};

    // When the high half also comes from the ALU, the ALU register
    // already holds that high byte. The low half then comes from the
    // hold captured at the low-byte index add
    always_comb begin
        case (flags.adlSel)
            ADL_DATA: adlBus = dataIn;
            ADL_ALU:  adlBus = (flags.adhSel == ADH_ALU) ? lowHold : aluReg;
            default:  adlBus = pc[`ADDR_DATA_W-1:0];
        endcase
    end

    always_comb begin
        case (flags.adhSel)
            ADH_DATA: adhBus = dataIn;
            ADH_ZERO: adhBus = '0;
            ADH_ALU:  adhBus = aluReg;
            default:  adhBus = pc[`ADDR_ADDR_W-1:`ADDR_DATA_W];
        endcase
    end

    //////////////////////////////////////////////////
    // Program counter and address latches
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc  <= '0;
            abl <= '0;
            abh <= '0;
        end else if (accept) begin
            // Put the first operand byte on the bus
            abl <= pc[`ADDR_DATA_W-1:0];
            abh <= pc[`ADDR_ADDR_W-1:`ADDR_DATA_W];
            pc  <= pc + PC_STEP;
        end else begin
            if (flags.pcInc) begin
                pc <= pc + PC_STEP;
            end else if (pcLoad) begin
                pc <= pcIn;
            end
            if (flags.loadAbl) begin
                abl <= adlBus;
            end
            if (flags.loadAbh) begin
                abh <= adhBus;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (flags.loadAlu) begin
            aluReg <= aluSum;
        end
        if (flags.latchCarry) begin
            lowHold <= aluSum;
        end
    end

    assign addrBus = {abh, abl};

    pcSingleSource: assert property (@(posedge clk) disable iff (!arstN)
        !(flags.pcInc && pcLoad));

endmodule

// File: verilog/addrUnit.sv
`include "addrParams.svh"

module addrUnit import addrPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    start,
    input  logic [7:0]              opCode,
    input  logic                    pcLoad,
    input  logic [`ADDR_ADDR_W-1:0] pcIn,
    input  logic [`ADDR_DATA_W-1:0] xReg,
    input  logic [`ADDR_DATA_W-1:0] yReg,
    input  logic [`ADDR_DATA_W-1:0] dataIn,
    output logic [`ADDR_ADDR_W-1:0] addrBus,
    output logic [`ADDR_ADDR_W-1:0] pc,
    output logic                    busy,
    output logic                    done
);

    addrMode_t  mode;
    addrMode_t  curMode;
    logic [2:0] stepCount;
    addrStep_t  step;
    logic       carryHold;
    logic       accept;
    logic       aluCarry;
    logic       pcLoadIdle;
    ctrlFlags_t flags;

    // PC reload only between instructions
    assign pcLoadIdle = pcLoad && !busy;

    addrModeDecode i_modeDecode (
        .opCode    (opCode),
        .mode      (mode),
        .stepCount (stepCount)
    );

    addrStepCtrl i_stepCtrl (
        .clk        (clk),
        .arstN      (arstN),
        .start      (start),
        .mode       (mode),
        .stepCount  (stepCount),
        .aluCarry   (aluCarry),
        .latchCarry (flags.latchCarry),
        .step       (step),
        .curMode    (curMode),
        .carryHold  (carryHold),
        .accept     (accept),
        .busy       (busy),
        .done       (done)
    );

    addrFlagGen i_flagGen (
        .step      (step),
        .curMode   (curMode),
        .carryHold (carryHold),
        .flags     (flags)
    );

    addrDatapath i_datapath (
        .clk      (clk),
        .arstN    (arstN),
        .flags    (flags),
        .accept   (accept),
        .pcLoad   (pcLoadIdle),
        .pcIn     (pcIn),
        .xReg     (xReg),
        .yReg     (yReg),
        .dataIn   (dataIn),
        .addrBus  (addrBus),
        .pc       (pc),
        .aluCarry (aluCarry)
    );

endmodule

// File: test/addrUnitTb.sv
`include "addrParams.svh"

module addrUnitTb import addrPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_RANDOM     = 200;
    localparam int NUM_DIRECTED   = 14;
    // Each instruction needs at most step count plus four edges
    localparam int TIMEOUT_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * (`ADDR_STEP_MAX + 4) + 100;

    logic        clk = 1'b0;
    logic        arstN;
    logic        start;
    logic [7:0]  opCode;
    logic        pcLoad;
    logic [15:0] pcIn;
    logic [7:0]  xReg;
    logic [7:0]  yReg;
    logic [7:0]  dataIn;
    logic [15:0] addrBus;
    logic [15:0] pc;
    logic        busy;
    logic        done;

    logic [7:0]  mem [0:65535];
    int          errCount = 0;
    int          testPass = 0;
    int          testFail = 0;
    int          testNum = 0;
    int          cycleCount = 0;

    opCode_t opList [10] = '{LDA_IMM, LDA_ZPG, LDA_ZPGX, LDX_ZPGY, LDA_ABS,
                             LDA_ABSX, LDA_ABSY, LDA_INDX, LDA_INDY, NOP};

    always #4 clk = ~clk;

    // Zero wait state memory
    assign dataIn = mem[addrBus];

    addrUnit i_addrUnit (
        .clk     (clk),
        .arstN   (arstN),
        .start   (start),
        .opCode  (opCode),
        .pcLoad  (pcLoad),
        .pcIn    (pcIn),
        .xReg    (xReg),
        .yReg    (yReg),
        .dataIn  (dataIn),
        .addrBus (addrBus),
        .pc      (pc),
        .busy    (busy),
        .done    (done)
    );

    //////////////////////////////////////////////////
    // Protocol properties
    //////////////////////////////////////////////////

    doneNeedsBusy: assert property (@(posedge clk) disable iff (!arstN) done |-> busy)
        else begin
            $display("FAIL busy: got %h, expected 1 while done is high", busy);
            errCount++;
        end

    busyUntilDone: assert property (@(posedge clk) disable iff (!arstN)
        (busy && !done) |=> busy)
        else begin
            $display("FAIL busy: dropped to %h before done was raised", busy);
            errCount++;
        end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, an instruction never finished",
                     cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Reference model, 6502 addressing rules
    //////////////////////////////////////////////////

    function automatic int modeSteps(input logic [7:0] op);
        case (op)
            LDA_IMM, LDA_ZPG:            return 1;
            LDA_ZPGX, LDX_ZPGY, LDA_ABS: return 2;
            LDA_ABSX, LDA_ABSY:          return 3;
            LDA_INDX, LDA_INDY:          return 4;
            default:                     return 0;
        endcase
    endfunction

    function automatic logic [15:0] operandBytes(input logic [7:0] op);
        case (op)
            LDA_ABS, LDA_ABSX, LDA_ABSY: return 16'd2;
            NOP:                         return 16'd0;
            LDA_IMM, LDA_ZPG, LDA_ZPGX, LDX_ZPGY, LDA_INDX, LDA_INDY: return 16'd1;
            default:                     return 16'd0;
        endcase
    endfunction

    function automatic logic [15:0] refAddr(input logic [7:0] op, input logic [15:0] pcs,
                                            input logic [7:0] x, input logic [7:0] y);
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [7:0]  ptr;
        logic [15:0] base;
        lo = mem[pcs];
        hi = mem[pcs + 16'd1];
        case (op)
            LDA_IMM:  return pcs;
            LDA_ZPG:  return {8'h00, lo};
            LDA_ZPGX: begin
                ptr = lo + x;
                return {8'h00, ptr};
            end
            LDX_ZPGY: begin
                ptr = lo + y;
                return {8'h00, ptr};
            end
            LDA_ABS:  return {hi, lo};
            LDA_ABSX: return {hi, lo} + {8'h00, x};
            LDA_ABSY: return {hi, lo} + {8'h00, y};
            LDA_INDX: begin
                // Both pointer bytes stay in page zero
                ptr = lo + x;
                base[7:0] = mem[{8'h00, ptr}];
                ptr = ptr + 8'd1;
                base[15:8] = mem[{8'h00, ptr}];
                return base;
            end
            LDA_INDY: begin
                ptr = lo;
                base[7:0] = mem[{8'h00, ptr}];
                ptr = ptr + 8'd1;
                base[15:8] = mem[{8'h00, ptr}];
                return base + {8'h00, y};
            end
            default:  return pcs;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////

    task automatic reportTest(input string name, input int errBefore);
        testNum++;
        if (errCount == errBefore) begin
            testPass++;
            $display("test %0d %s: ok", testNum, name);
        end else begin
            testFail++;
            $display("test %0d %s: failed", testNum, name);
        end
    endtask

    // One instruction from pc load to the idle cycle after done
    task automatic runInstr(input string name, input logic [7:0] op,
                            input logic [15:0] pcStart, input logic [7:0] x,
                            input logic [7:0] y, input bit strayStart);
        logic [15:0] expAddr;
        logic [15:0] expPc;
        int          expCycles;
        int          cycles;
        int          errBefore;
        bit          finished;
        errBefore = errCount;
        expAddr   = refAddr(op, pcStart, x, y);
        expPc     = pcStart + 16'd1 + operandBytes(op);
        expCycles = modeSteps(op) + 1;

        @(posedge clk);
        pcLoad <= 1'b1;
        pcIn   <= pcStart;
        xReg   <= x;
        yReg   <= y;
        @(posedge clk);
        pcLoad <= 1'b0;
        start  <= 1'b1;
        opCode <= op;
        @(negedge clk);
        assert (!busy && pc == pcStart) else begin
            $display("FAIL pc: got %h, expected %h (busy %h)", pc, pcStart, busy);
            errCount++;
        end
        @(posedge clk);
        start <= 1'b0;

        cycles   = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);
            cycles++;
            assert (busy) else begin
                $display("FAIL busy: got %h, expected 1 in cycle %0d", busy, cycles);
                errCount++;
            end
            if (done) begin
                finished = 1'b1;
            end else begin
                @(posedge clk);
                // Extra strobe while busy, must be dropped
                if (strayStart && cycles == 1) begin
                    start  <= 1'b1;
                    opCode <= LDA_IMM;
                end else begin
                    start <= 1'b0;
                end
            end
        end

        assert (cycles == expCycles) else begin
            $display("FAIL done: latency %h cycles, expected %h", cycles, expCycles);
            errCount++;
        end
        if (modeSteps(op) != 0) begin
            assert (addrBus == expAddr) else begin
                $display("FAIL addrBus: got %h, expected %h", addrBus, expAddr);
                errCount++;
            end
        end
        assert (pc == expPc) else begin
            $display("FAIL pc: got %h, expected %h", pc, expPc);
            errCount++;
        end

        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        assert (!done && !busy) else begin
            $display("FAIL done: got %h, busy got %h, expected 0 after done", done, busy);
            errCount++;
        end
        reportTest(name, errBefore);
    endtask

    initial begin
        int errBefore;
        arstN  = 1'b0;
        start  = 1'b0;
        opCode = 8'h00;
        pcLoad = 1'b0;
        pcIn   = 16'h0000;
        xReg   = 8'h00;
        yReg   = 8'h00;

        void'($urandom(32'h0032_dbe1));
        for (int i = 0; i < 65536; i++) begin
            mem[16'(i)] = 8'($urandom);
        end

        repeat (10) @(posedge clk);
        arstN <= 1'b1;

        // Reset state
        errBefore = errCount;
        @(negedge clk);
        assert (!busy && !done) else begin
            $display("FAIL busy/done: got %h/%h after reset, expected 0/0", busy, done);
            errCount++;
        end
        assert (addrBus == 16'h0000 && pc == 16'h0000) else begin
            $display("FAIL addrBus/pc: got %h/%h after reset, expected 0000/0000",
                     addrBus, pc);
            errCount++;
        end
        reportTest("reset state", errBefore);

        ////////////////////////////////////////////////// 
        // Page carry and zero page wrap corners
        //////////////////////////////////////////////////

        mem[16'h0300] = 8'hF0;
        mem[16'h0301] = 8'h12;
        runInstr("absx page cross", LDA_ABSX, 16'h0300, 8'h20, 8'h00, 1'b0);
        mem[16'h0400] = 8'hFF;
        mem[16'h0401] = 8'h34;
        runInstr("absy page cross", LDA_ABSY, 16'h0400, 8'h00, 8'h01, 1'b0);
        mem[16'h0480] = 8'hFF;
        mem[16'h0481] = 8'hFF;
        runInstr("absx top wrap", LDA_ABSX, 16'h0480, 8'h01, 8'h00, 1'b0);
        mem[16'h0500] = 8'h40;
        mem[16'h0040] = 8'hC0;
        mem[16'h0041] = 8'h22;
        runInstr("indy page cross", LDA_INDY, 16'h0500, 8'h00, 8'h80, 1'b0);
        mem[16'h0600] = 8'hFF;
        mem[16'h00FF] = 8'h10;
        mem[16'h0000] = 8'h20;
        runInstr("indy pointer wrap", LDA_INDY, 16'h0600, 8'h00, 8'hF0, 1'b0);
        mem[16'h0700] = 8'hF0;
        runInstr("zpgx wrap", LDA_ZPGX, 16'h0700, 8'h20, 8'h00, 1'b0);
        mem[16'h0800] = 8'hFF;
        runInstr("zpgy wrap", LDX_ZPGY, 16'h0800, 8'h00, 8'h02, 1'b0);
        mem[16'h0900] = 8'hF0;
        mem[16'h00FF] = 8'h78;
        mem[16'h0000] = 8'h56;
        runInstr("indx pointer at ff", LDA_INDX, 16'h0900, 8'h0F, 8'h00, 1'b0);
        mem[16'h0A00] = 8'h80;
        runInstr("indx sum wrap", LDA_INDX, 16'h0A00, 8'h90, 8'h00, 1'b0);
        mem[16'hFFFF] = 8'h34;
        mem[16'h0000] = 8'h12;
        runInstr("abs pc wrap", LDA_ABS, 16'hFFFF, 8'h00, 8'h00, 1'b0);

        // Start while busy and unknown opcode
        runInstr("indy stray start", LDA_INDY, 16'h0B00, 8'h00, 8'h33, 1'b1);
        runInstr("absx stray start", LDA_ABSX, 16'h0C00, 8'hC4, 8'h00, 1'b1);
        runInstr("zpg stray start", LDA_ZPG, 16'h0D00, 8'h00, 8'h00, 1'b1);
        runInstr("unknown opcode", 8'h02, 16'h0E00, 8'h00, 8'h00, 1'b0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            runInstr($sformatf("random %0d", i), opList[$urandom_range(0, 9)],
                     16'($urandom), 8'($urandom), 8'($urandom), 1'($urandom));
        end

        $display("tests passed %0d, failed %0d", testPass, testFail);
        if (errCount == 0 && testFail == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
verilog/addrPkg.sv
verilog/addrModeDecode.sv
verilog/addrStepCtrl.sv
verilog/addrFlagGen.sv
verilog/addrDatapath.sv
verilog/addrUnit.sv
test/addrUnitTb.sv

// File: run.sh
#!/bin/sh
# Builds the addrUnit testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module addrUnitTb -f src.f -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "No pass message found in sim.log"
    exit 1
fi
exit 0
